// ==== verilog/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	////////////////////
	// Widths and fixed values

	// Data and instruction width
	localparam int xlen = 32;
	// Register address width
	localparam int reg_aw = 5;
	localparam int reg_count = 2 ** reg_aw;
	// Opcode and function code width
	localparam int op_w = 6;

	// Destination written by jal
	localparam logic [reg_aw-1:0] link_reg = 5'd31;
	// Second operand passed down the pipe on a jump
	localparam logic [xlen-1:0] link_offset = 32'd4;

	////////////////////
	// Opcodes

	localparam logic [op_w-1:0] op_rtype = 6'h00;
	localparam logic [op_w-1:0] op_j     = 6'h02;
	localparam logic [op_w-1:0] op_jal   = 6'h03;
	localparam logic [op_w-1:0] op_beq   = 6'h04;
	localparam logic [op_w-1:0] op_bne   = 6'h05;
	localparam logic [op_w-1:0] op_addi  = 6'h08;
	localparam logic [op_w-1:0] op_slti  = 6'h0a;
	localparam logic [op_w-1:0] op_andi  = 6'h0c;
	localparam logic [op_w-1:0] op_ori   = 6'h0d;
	localparam logic [op_w-1:0] op_lui   = 6'h0f;
	localparam logic [op_w-1:0] op_lw    = 6'h23;
	localparam logic [op_w-1:0] op_sw    = 6'h2b;

	// R-type jumps through a register
	localparam logic [op_w-1:0] fn_jr   = 6'h08;
	localparam logic [op_w-1:0] fn_jalr = 6'h09;

	////////////////////
	// Shared bundles

	// Pipeline control, 15 bits
	typedef struct packed {
		logic            reg_write;
		logic            mem_to_reg;
		logic            mem_write;
		logic            reg_dst;
		logic            alu_src;
		logic [op_w-1:0] alu_op;
		logic            branch_eq;
		logic            branch_ne;
		logic            jump;
		logic            jump_reg;
	} ctrl_t;

	// Writeback port from the last stage, 38 bits
	typedef struct packed {
		logic              en;
		logic [reg_aw-1:0] addr;
		logic [xlen-1:0]   data;
	} wb_port_t;

endpackage

`default_nettype wire

// ==== verilog/control_unit.sv ====
`default_nettype none

module control_unit (
	input  wire logic [mips_pkg::op_w-1:0] opcode,
	input  wire logic [mips_pkg::op_w-1:0] func,
	output mips_pkg::ctrl_t                ctrl
);

	always_comb begin
		// Unknown opcodes fall through with everything low
		ctrl = '0;

		case (opcode)
			mips_pkg::op_rtype: begin
				ctrl.reg_dst = 1'b1;
				ctrl.alu_op = func;
				// jr is the only R-type with no destination
				ctrl.reg_write = (func != mips_pkg::fn_jr);
				if (func == mips_pkg::fn_jr || func == mips_pkg::fn_jalr) begin
					ctrl.jump = 1'b1;
					ctrl.jump_reg = 1'b1;
				end
			end

			////////////////////
			// Memory access

			mips_pkg::op_lw: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.alu_op = opcode;
			end
			mips_pkg::op_sw: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.alu_op = opcode;
			end

			////////////////////
			// Control flow

			mips_pkg::op_beq: begin
				ctrl.branch_eq = 1'b1;
				ctrl.alu_op = opcode;
			end
			mips_pkg::op_bne: begin
				ctrl.branch_ne = 1'b1;
				ctrl.alu_op = opcode;
			end
			mips_pkg::op_j: begin
				ctrl.jump = 1'b1;
				ctrl.alu_op = opcode;
			end
			mips_pkg::op_jal: begin
				// Link value is written back to r31
				ctrl.jump = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.alu_op = opcode;
			end

			// Immediate arithmetic and logic
			mips_pkg::op_addi, mips_pkg::op_andi, mips_pkg::op_ori,
			mips_pkg::op_slti, mips_pkg::op_lui: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.alu_op = opcode;
			end

			default: ctrl = '0;
		endcase

		// Both branch kinds at once would confuse the compare
		assert (!(ctrl.branch_eq && ctrl.branch_ne))
			else $error("control_unit: beq and bne both set, opcode %h", opcode);
	end

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
`default_nettype none

module register_file (
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire logic [mips_pkg::reg_aw-1:0]   raddr1,
	input  wire logic [mips_pkg::reg_aw-1:0]   raddr2,
	input  wire mips_pkg::wb_port_t            wb,
	output logic      [mips_pkg::xlen-1:0]     rdata1,
	output logic      [mips_pkg::xlen-1:0]     rdata2
);

	logic [mips_pkg::xlen-1:0] regs [mips_pkg::reg_count];
	logic                      hit1;
	logic                      hit2;

	////////////////////
	// Write port

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < mips_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.en && wb.addr != '0) begin
			regs[wb.addr] <= wb.data;
		end
	end

	////////////////////
	// Read ports

	// Same-cycle writeback overrides the stored value
	assign hit1 = wb.en && (wb.addr == raddr1);
	assign hit2 = wb.en && (wb.addr == raddr2);

	// r0 is hard-wired, writes to it never show up
	assign rdata1 = (raddr1 == '0) ? '0 : (hit1 ? wb.data : regs[raddr1]);
	assign rdata2 = (raddr2 == '0) ? '0 : (hit2 ? wb.data : regs[raddr2]);

	// Storage for r0 must survive every writeback, including one aimed at it
	zero_reg_kept: assert property (
		@(posedge clk) disable iff (!rst_n)
		wb.en |=> (regs[0] == '0)
	) else $error("register_file: r0 storage changed after a write");

endmodule

`default_nettype wire

// ==== verilog/branch_resolve.sv ====
`default_nettype none

module branch_resolve (
	input  wire mips_pkg::ctrl_t           ctrl,
	input  wire logic [mips_pkg::xlen-1:0] opnd1,
	input  wire logic [mips_pkg::xlen-1:0] opnd2,
	input  wire logic [mips_pkg::xlen-1:0] imm_ext,
	input  wire logic [mips_pkg::xlen-1:0] pc_incr,
	input  wire logic [mips_pkg::xlen-1:0] rdata1,
	input  wire logic [mips_pkg::xlen-1:0] alu_result_ex,
	input  wire logic [mips_pkg::xlen-1:0] mem_result,
	input  wire logic [25:0]               target_field,
	input  wire logic                      forward_a,
	input  wire logic                      forward_b,
	output logic      [mips_pkg::xlen-1:0] pc_branch,
	output logic      [mips_pkg::xlen-1:0] pc_jump,
	output logic                           branch_taken
);

	logic [mips_pkg::xlen-1:0] cmp_a;
	logic [mips_pkg::xlen-1:0] cmp_b;
	logic [mips_pkg::xlen-1:0] j_target;
	logic [mips_pkg::xlen-1:0] jr_target;
	logic                      ops_equal;

	////////////////////
	// Early branch decision

	// Result from the memory stage replaces a stale register value
	assign cmp_a = forward_a ? mem_result : opnd1;
	assign cmp_b = forward_b ? mem_result : opnd2;
	assign ops_equal = (cmp_a == cmp_b);

	// Word offset relative to the next instruction
	assign pc_branch = pc_incr + {imm_ext[mips_pkg::xlen-3:0], 2'b00};

	always_comb begin
		branch_taken = (ctrl.branch_eq && ops_equal) || (ctrl.branch_ne && !ops_equal);

		assert (!branch_taken || ctrl.branch_eq || ctrl.branch_ne)
			else $error("branch_resolve: taken without a branch instruction");
	end

	////////////////////
	// Jump target

	// j and jal stay inside the current 256 MB region
	assign j_target = {pc_incr[mips_pkg::xlen-1:mips_pkg::xlen-4], target_field, 2'b00};

	// Register still in flight in execute, take the ALU result
	assign jr_target = (forward_a || forward_b) ? alu_result_ex : rdata1;

	assign pc_jump = ctrl.jump_reg ? jr_target : j_target;

endmodule

`default_nettype wire

// ==== verilog/instruction_decode.sv ====
`default_nettype none

module instruction_decode (
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire logic [mips_pkg::xlen-1:0]     instruction,
	input  wire logic [mips_pkg::xlen-1:0]     pc_incr,
	input  wire mips_pkg::wb_port_t            wb,
	input  wire logic [mips_pkg::xlen-1:0]     alu_result_ex,
	input  wire logic [mips_pkg::xlen-1:0]     mem_result,
	input  wire logic                          forward_a,
	input  wire logic                          forward_b,
	output mips_pkg::ctrl_t                    ctrl,
	output logic      [mips_pkg::xlen-1:0]     reg_data1,
	output logic      [mips_pkg::xlen-1:0]     reg_data2,
	output logic      [mips_pkg::xlen-1:0]     imm_ext,
	output logic      [mips_pkg::reg_aw-1:0]   rs,
	output logic      [mips_pkg::reg_aw-1:0]   rt,
	output logic      [mips_pkg::reg_aw-1:0]   rd,
	output logic      [mips_pkg::op_w-1:0]     opcode,
	output logic      [mips_pkg::op_w-1:0]     func,
	output logic      [mips_pkg::xlen-1:0]     pc_branch,
	output logic      [mips_pkg::xlen-1:0]     pc_jump,
	output logic                               branch_taken
);

	logic [mips_pkg::xlen-1:0] rdata1;
	logic [mips_pkg::xlen-1:0] rdata2;

	////////////////////
	// Instruction fields

	assign opcode = instruction[31:26];
	assign rs = instruction[25:21];
	assign rt = instruction[20:16];
	assign func = instruction[5:0];
	assign imm_ext = {{16{instruction[15]}}, instruction[15:0]};

	// j and jal link into r31, jalr keeps its encoded rd
	assign rd = (ctrl.jump && !ctrl.jump_reg) ? mips_pkg::link_reg : instruction[15:11];

	control_unit control_i (
		.opcode (opcode),
		.func   (func),
		.ctrl   (ctrl)
	);

	register_file regfile_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.raddr1 (rs),
		.raddr2 (rt),
		.wb     (wb),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	////////////////////
	// Operands

	// On a jump the ALU computes pc_incr + 4 as the link value
	assign reg_data1 = ctrl.jump ? pc_incr : rdata1;
	assign reg_data2 = ctrl.jump ? mips_pkg::link_offset : rdata2;

	branch_resolve branch_i (
		.ctrl          (ctrl),
		.opnd1         (reg_data1),
		.opnd2         (reg_data2),
		.imm_ext       (imm_ext),
		.pc_incr       (pc_incr),
		.rdata1        (rdata1),
		.alu_result_ex (alu_result_ex),
		.mem_result    (mem_result),
		.target_field  (instruction[25:0]),
		.forward_a     (forward_a),
		.forward_b     (forward_b),
		.pc_branch     (pc_branch),
		.pc_jump       (pc_jump),
		.branch_taken  (branch_taken)
	);

endmodule

`default_nettype wire

// ==== bench/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

`default_nettype none

// Expected decode outputs for one cycle
typedef struct packed {
	mips_pkg::ctrl_t ctrl;
	logic [31:0]     reg_data1;
	logic [31:0]     reg_data2;
	logic [31:0]     imm_ext;
	logic [4:0]      rs;
	logic [4:0]      rt;
	logic [4:0]      rd;
	logic [5:0]      opcode;
	logic [5:0]      func;
	logic [31:0]     pc_branch;
	logic [31:0]     pc_jump;
	logic            branch_taken;
} expect_t;

function automatic expect_t model_decode(
	input logic [31:0]        instr,
	input logic [31:0]        pc,
	input logic [31:0]        regs [32],
	input mips_pkg::wb_port_t w,
	input logic [31:0]        alu,
	input logic [31:0]        mem,
	input logic               fa,
	input logic               fb
);
	expect_t     e;
	logic [5:0]  op;
	logic [5:0]  fn;
	logic        is_r;
	logic        is_imm;
	logic        is_jreg;
	logic [31:0] rd1;
	logic [31:0] rd2;
	logic [31:0] cmp_a;
	logic [31:0] cmp_b;

	op = instr[31:26];
	fn = instr[5:0];
	is_r = (op == mips_pkg::op_rtype);
	is_imm = op inside {mips_pkg::op_addi, mips_pkg::op_andi, mips_pkg::op_ori,
		mips_pkg::op_slti, mips_pkg::op_lui};
	is_jreg = is_r && (fn == mips_pkg::fn_jr || fn == mips_pkg::fn_jalr);

	e = '0;
	e.opcode = op;
	e.func = fn;
	e.rs = instr[25:21];
	e.rt = instr[20:16];
	e.imm_ext = {{16{instr[15]}}, instr[15:0]};
	e.pc_branch = pc + (e.imm_ext << 2);

	////////////////////
	// Control bundle
	e.ctrl.reg_write = (is_r && fn != mips_pkg::fn_jr) || op == mips_pkg::op_lw || is_imm
		|| op == mips_pkg::op_jal;
	e.ctrl.mem_to_reg = (op == mips_pkg::op_lw);
	e.ctrl.mem_write = (op == mips_pkg::op_sw);
	e.ctrl.reg_dst = is_r;
	e.ctrl.alu_src = is_imm || op == mips_pkg::op_lw || op == mips_pkg::op_sw;
	e.ctrl.branch_eq = (op == mips_pkg::op_beq);
	e.ctrl.branch_ne = (op == mips_pkg::op_bne);
	e.ctrl.jump = is_jreg || op == mips_pkg::op_j || op == mips_pkg::op_jal;
	e.ctrl.jump_reg = is_jreg;
	// Every known non R-type opcode raises some flag, unknown ones stay all zero
	if (is_r) begin
		e.ctrl.alu_op = fn;
	end else if (e.ctrl != '0) begin
		e.ctrl.alu_op = op;
	end

	// Region jumps name r31 as destination
	if (op == mips_pkg::op_j || op == mips_pkg::op_jal) begin
		e.rd = mips_pkg::link_reg;
	end else begin
		e.rd = instr[15:11];
	end

	////////////////////
	// Register reads, r0 is zero and a pending write is seen at once
	if (e.rs == '0) begin
		rd1 = '0;
	end else begin
		rd1 = (w.en && w.addr == e.rs) ? w.data : regs[e.rs];
	end
	if (e.rt == '0) begin
		rd2 = '0;
	end else begin
		rd2 = (w.en && w.addr == e.rt) ? w.data : regs[e.rt];
	end
	e.reg_data1 = e.ctrl.jump ? pc : rd1;
	e.reg_data2 = e.ctrl.jump ? 32'd4 : rd2;

	cmp_a = fa ? mem : e.reg_data1;
	cmp_b = fb ? mem : e.reg_data2;
	e.branch_taken = (e.ctrl.branch_eq && cmp_a == cmp_b) || (e.ctrl.branch_ne && cmp_a != cmp_b);

	if (e.ctrl.jump_reg) begin
		e.pc_jump = (fa || fb) ? alu : rd1;
	end else begin
		e.pc_jump = {pc[31:28], instr[25:0], 2'b00};
	end
	return e;
endfunction

`default_nettype wire

`endif

// ==== bench/decode_tb.sv ====
`default_nettype none

module decode_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int clk_period = 4;
	localparam int directed_steps = 80;
	localparam int random_steps = 500;
	// Reset, both test phases and some slack
	localparam int timeout_ns = (2 + directed_steps + random_steps + 10) * clk_period;

	localparam logic [5:0] known_ops [12] = '{
		mips_pkg::op_rtype, mips_pkg::op_lw, mips_pkg::op_sw, mips_pkg::op_beq,
		mips_pkg::op_bne, mips_pkg::op_j, mips_pkg::op_jal, mips_pkg::op_addi,
		mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_slti, mips_pkg::op_lui
	};

	logic               clk;
	logic               rst_n;
	logic [31:0]        instruction;
	logic [31:0]        pc_incr;
	mips_pkg::wb_port_t wb;
	logic [31:0]        alu_result_ex;
	logic [31:0]        mem_result;
	logic               forward_a;
	logic               forward_b;
	mips_pkg::ctrl_t    ctrl;
	logic [31:0]        reg_data1;
	logic [31:0]        reg_data2;
	logic [31:0]        imm_ext;
	logic [4:0]         rs;
	logic [4:0]         rt;
	logic [4:0]         rd;
	logic [5:0]         opcode;
	logic [5:0]         func;
	logic [31:0]        pc_branch;
	logic [31:0]        pc_jump;
	logic               branch_taken;

	// Mirror of the stored register contents
	logic [31:0] shadow [32];
	int          seed;
	int          errors;
	int          checks;

	`include "decode_model.svh"

	instruction_decode dut_i (.*);

	always #(clk_period / 2) clk = ~clk;

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				shadow[i] <= '0;
			end
		end else if (wb.en) begin
			shadow[wb.addr] <= wb.data;
		end
	end

	function automatic logic [31:0] rtype(input logic [4:0] s, input logic [4:0] t,
		input logic [4:0] d, input logic [5:0] fn);
		return {mips_pkg::op_rtype, s, t, d, 5'd0, fn};
	endfunction

	function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] s,
		input logic [4:0] t, input logic [15:0] imm);
		return {op, s, t, imm};
	endfunction

	function automatic logic [31:0] jtype(input logic [5:0] op, input logic [25:0] target);
		return {op, target};
	endfunction

	function automatic mips_pkg::wb_port_t writeback(input logic en, input logic [4:0] addr,
		input logic [31:0] data);
		mips_pkg::wb_port_t w;
		w.en = en;
		w.addr = addr;
		w.data = data;
		return w;
	endfunction

	task automatic drive(input logic [31:0] instr, input logic [31:0] pc,
		input mips_pkg::wb_port_t w, input logic [31:0] alu, input logic [31:0] mem,
		input logic fa, input logic fb);
		@(posedge clk);
		instruction <= instr;
		pc_incr <= pc;
		wb <= w;
		alu_result_ex <= alu;
		mem_result <= mem;
		forward_a <= fa;
		forward_b <= fb;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	////////////////////
	// Compare, one clock before the next edge
	initial begin
		expect_t exp;
		forever begin
			@(posedge clk);
			#(clk_period - 1);
			if (rst_n) begin
				exp = model_decode(instruction, pc_incr, shadow, wb, alu_result_ex,
					mem_result, forward_a, forward_b);
				check_value("ctrl", 32'(ctrl), 32'(exp.ctrl));
				check_value("reg_data1", reg_data1, exp.reg_data1);
				check_value("reg_data2", reg_data2, exp.reg_data2);
				check_value("imm_ext", imm_ext, exp.imm_ext);
				check_value("rs", 32'(rs), 32'(exp.rs));
				check_value("rt", 32'(rt), 32'(exp.rt));
				check_value("rd", 32'(rd), 32'(exp.rd));
				check_value("opcode", 32'(opcode), 32'(exp.opcode));
				check_value("func", 32'(func), 32'(exp.func));
				check_value("pc_branch", pc_branch, exp.pc_branch);
				check_value("pc_jump", pc_jump, exp.pc_jump);
				check_value("branch_taken", 32'(branch_taken), 32'(exp.branch_taken));
			end
		end
	end

	////////////////////
	// Stimulus
	initial begin
		logic [31:0] word;
		logic [31:0] bits;
		seed = 54054;
		errors = 0;
		checks = 0;
		clk = 1'b0;
		rst_n = 1'b0;
		instruction = '0;
		pc_incr = '0;
		wb = '0;
		alu_result_ex = '0;
		mem_result = '0;
		forward_a = 1'b0;
		forward_b = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// Every register reads zero after reset
		for (int r = 0; r < 32; r += 2) begin
			drive(rtype(5'(r), 5'(r + 1), 5'd0, 6'h20), 32'h0040_0000, '0, '0, '0, 1'b0, 1'b0);
		end
		// Writes seen through the bypass, r0 write dropped, then read back
		for (int r = 0; r < 8; r++) begin
			drive(rtype(5'(r), 5'd0, 5'd0, 6'h20), 32'h0040_0004,
				writeback(1'b1, 5'(r), 32'(r) * 32'h0101_0101 ^ 32'h5a00_00a5),
				'0, '0, 1'b0, 1'b0);
		end
		for (int r = 0; r < 8; r++) begin
			drive(rtype(5'(r), 5'(7 - r), 5'd0, 6'h20), 32'h0040_0008, '0, '0, '0, 1'b0, 1'b0);
		end

		// Opcode sweep with both immediate signs, jr, jalr and an unknown opcode
		for (int k = 0; k < 15; k++) begin
			case (k)
				12: word = rtype(5'd3, 5'd0, 5'd0, mips_pkg::fn_jr);
				13: word = rtype(5'd4, 5'd0, 5'd9, mips_pkg::fn_jalr);
				14: word = itype(6'h3f, 5'd3, 5'd4, 16'hfffc);
				default: word = itype(known_ops[4'(k)], 5'd3, 5'd4, 16'(k * 4937));
			endcase
			drive(word, 32'h1040_0100, '0, '0, '0, 1'b0, 1'b0);
		end

		// beq and bne, equal and unequal, with each forwarding mix
		for (int k = 0; k < 16; k++) begin
			word = itype(k[3] ? mips_pkg::op_bne : mips_pkg::op_beq, 5'd1,
				k[0] ? 5'd2 : 5'd1, 16'hfff0);
			drive(word, 32'h0040_0200, '0, '0, shadow[5'd2], k[1], k[2]);
		end

		// Region jumps and register jumps
		for (int k = 0; k < 4; k++) begin
			drive(jtype(mips_pkg::op_j, 26'h2a5_5a5a), 32'hb000_1000, '0, '0, '0, k[0], k[1]);
			drive(jtype(mips_pkg::op_jal, 26'h155_a5a5), 32'h7fff_fffc, '0, '0, '0, k[0], k[1]);
			drive(rtype(5'd5, 5'd0, 5'd0, mips_pkg::fn_jr), 32'h0040_0300, '0,
				32'h0bad_f00d, '0, k[0], k[1]);
			drive(rtype(5'd6, 5'd0, 5'd31, mips_pkg::fn_jalr), 32'h0040_0304, '0,
				32'h0bad_f00d, '0, k[0], k[1]);
		end

		// Random mix, mostly known opcodes
		for (int n = 0; n < random_steps; n++) begin
			word = $random(seed);
			bits = $random(seed);
			if (bits[1:0] != 2'b00) begin
				word[31:26] = known_ops[4'(int'(bits[7:4]) % 12)];
			end
			if (word[31:26] == mips_pkg::op_rtype && bits[8]) begin
				word[5:0] = bits[9] ? mips_pkg::fn_jalr : mips_pkg::fn_jr;
			end
			drive(word, $random(seed), writeback(bits[10], bits[15:11], $random(seed)),
				$random(seed), bits[16] ? shadow[word[20:16]] : $random(seed),
				bits[17], bits[18]);
		end

		@(posedge clk);
		$display("decode_tb: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		#(timeout_ns);
		$display("decode_tb: watchdog expired, stimulus did not finish within %0d ns", timeout_ns);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mips_decode.f ====
+incdir+bench
verilog/mips_pkg.sv
verilog/control_unit.sv
verilog/register_file.sv
verilog/branch_resolve.sv
verilog/instruction_decode.sv
bench/decode_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the decode stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Mdir obj_dir --top-module decode_tb \
	-f mips_decode.f -o decode_sim &&
	./obj_dir/decode_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
	echo "run_sim: pass" && exit 0 ||
	{ echo "run_sim: fail"; exit 1; }
